//--- replay_pkg.sv
`default_nettype none

package replay_pkg;

  // Queue layout in external SRAM
  localparam int num_queues = 4;
  localparam int qid_bits = 2;

  // SRAM word address; queue ID forms the top bits
  localparam int mem_addr_width = 10;

  // Per-queue head and tail pointers within one quarter of SRAM
  localparam int head_width = mem_addr_width - qid_bits;

  // One half of an SRAM return word
  localparam int mem_half_width = 36;

  // Output word is high half followed by low half
  localparam int word_width = 2 * mem_half_width;

  // Queue-ID FIFO holds one entry per read in flight
  localparam int qid_fifo_depth_bits = 4;

  // Output FIFO depth per queue
  localparam int out_fifo_depth_bits = 6;

  // Prog-full margin on the output FIFOs
  // 16 reads in flight plus 3 return pipeline registers must still fit
  localparam int out_prog_full_free = 24;

  // Arbiter FSM states
  typedef enum logic {
    ARB_SELECT,
    ARB_ISSUE
  } arb_state_t;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int width = 8,
  parameter int depth_bits = 4,
  parameter int prog_full_free = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic             rd_en,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout,
  output logic             full,
  output logic             nearly_full,
  output logic             prog_full,
  output logic             empty
);

  localparam logic [depth_bits:0] depth = (depth_bits + 1)'(1) << depth_bits;
  localparam logic [depth_bits:0] nearly_level = depth - (depth_bits + 1)'(1);
  localparam logic [depth_bits:0] prog_level = depth - (depth_bits + 1)'(prog_full_free);

  logic [width-1:0]      mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;
  logic                  wr_fire;
  logic                  rd_fire;

  assign wr_fire = wr_en && !full;
  assign rd_fire = rd_en && !empty;

  // Fall-through: head entry is visible without a read
  assign dout = mem[rd_ptr];

  // Flags from occupancy
  assign full = (count == depth);
  assign nearly_full = (count >= nearly_level);
  assign prog_full = (count >= prog_level);
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + depth_bits'(1);
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + depth_bits'(1);
      end
      // Simultaneous push and pop leaves occupancy unchanged
      if (wr_fire && !rd_fire) begin
        count <= count + (depth_bits + 1)'(1);
      end else if (rd_fire && !wr_fire) begin
        count <= count - (depth_bits + 1)'(1);
      end
    end
  end

  // Upstream flow control must keep these from happening
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> !full
  ) else $error("sync_fifo write while full");

  a_no_read_when_empty: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> !empty
  ) else $error("sync_fifo read while empty");

endmodule

`default_nettype wire

//--- queue_arbiter.sv
`default_nettype none

module queue_arbiter import replay_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cal_done,
  input  logic                                 mem_rd_full,
  output logic                                 mem_r_n,
  output logic [mem_addr_width-1:0]            mem_ad_rd,
  input  logic [num_queues-1:0][head_width-1:0] q_addr_tail,
  output logic [num_queues-1:0][head_width-1:0] q_addr_head,
  input  logic [num_queues-1:0]                out_prog_full,
  input  logic                                 qid_nearly_full,
  output logic                                 qid_wr_en,
  output logic [qid_bits-1:0]                  qid_din
);

  arb_state_t          arb_state;
  arb_state_t          state_next;
  logic                sel_valid;
  logic                sel_valid_next;
  logic [qid_bits-1:0] sel_qid;
  logic [qid_bits-1:0] sel_qid_next;
  logic [qid_bits-1:0] last_qid;
  logic [num_queues-1:0] q_enable;
  logic                pick_valid;
  logic [qid_bits-1:0] pick_qid;
  logic [qid_bits-1:0] cand;
  logic                issue;
  logic                arb_rst;

  // Held idle until memory calibration completes
  assign arb_rst = rst || !cal_done;

  // A queue is eligible when it has unread words and downstream room
  always_comb begin
    for (int q = 0; q < num_queues; q++) begin
      q_enable[q] = !out_prog_full[q] && (q_addr_head[q] != q_addr_tail[q]);
    end
  end

  // Round-robin search starting just after the last queue served
  always_comb begin
    pick_valid = 1'b0;
    pick_qid = last_qid;
    cand = last_qid;
    for (int i = 1; i <= num_queues; i++) begin
      cand = last_qid + qid_bits'(i);
      if (!pick_valid && q_enable[cand]) begin
        pick_valid = 1'b1;
        pick_qid = cand;
      end
    end
  end

  assign issue = (arb_state == ARB_ISSUE) && sel_valid && !mem_rd_full && !qid_nearly_full;

  // SRAM read and queue-ID push happen together
  assign mem_r_n = !issue;
  assign mem_ad_rd = issue ? {sel_qid, q_addr_head[sel_qid]} : '0;
  assign qid_wr_en = issue;
  assign qid_din = sel_qid;

  always_comb begin
    state_next = arb_state;
    sel_valid_next = sel_valid;
    sel_qid_next = sel_qid;
    case (arb_state)
      ARB_SELECT: begin
        sel_valid_next = pick_valid;
        sel_qid_next = pick_qid;
        state_next = ARB_ISSUE;
      end
      ARB_ISSUE: begin
        // Wait here while back-pressured
        if (!sel_valid || issue) begin
          state_next = ARB_SELECT;
        end
      end
      default: begin
        state_next = ARB_SELECT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (arb_rst) begin
      arb_state <= ARB_SELECT;
      sel_valid <= 1'b0;
      sel_qid <= '0;
      // First search then starts at queue 0
      last_qid <= qid_bits'(num_queues - 1);
      q_addr_head <= '0;
    end else begin
      arb_state <= state_next;
      sel_valid <= sel_valid_next;
      sel_qid <= sel_qid_next;
      if (issue) begin
        last_qid <= sel_qid;
        q_addr_head[sel_qid] <= q_addr_head[sel_qid] + head_width'(1);
      end
    end
  end

  a_no_read_when_rd_full: assert property (
    @(posedge clk) disable iff (arb_rst) !mem_r_n |-> !mem_rd_full
  ) else $error("SRAM read issued while mem_rd_full");

  a_read_pushes_qid: assert property (
    @(posedge clk) disable iff (arb_rst) !mem_r_n |-> qid_wr_en
  ) else $error("SRAM read without queue-ID push");

endmodule

`default_nettype wire

//--- read_return_steer.sv
`default_nettype none

module read_return_steer import replay_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_qr_valid,
  input  logic [mem_half_width-1:0] mem_qrl,
  input  logic [mem_half_width-1:0] mem_qrh,
  output logic                      qid_rd_en,
  input  logic [qid_bits-1:0]       qid_dout,
  input  logic                      qid_empty,
  output logic [num_queues-1:0]     out_wr_en,
  output logic [word_width-1:0]     out_din
);

  logic [num_queues-1:0] wr_en_s0;
  logic [num_queues-1:0] wr_en_s1;
  logic [word_width-1:0] din_s0;
  logic [word_width-1:0] din_s1;

  // Returns come back in issue order, so the FIFO head names the queue
  assign qid_rd_en = mem_qr_valid;

  // Stage 0: decode queue ID and capture the word
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_s0 <= '0;
    end else if (mem_qr_valid) begin
      wr_en_s0 <= num_queues'(1) << qid_dout;
    end else begin
      wr_en_s0 <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_qr_valid) begin
      din_s0 <= {mem_qrh, mem_qrl};
    end
  end

  // Two more register stages toward the output FIFOs
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_s1 <= '0;
      out_wr_en <= '0;
    end else begin
      wr_en_s1 <= wr_en_s0;
      out_wr_en <= wr_en_s1;
    end
  end

  always_ff @(posedge clk) begin
    din_s1 <= din_s0;
    out_din <= din_s1;
  end

  // Every return must match a read recorded by the arbiter
  a_return_has_qid: assert property (
    @(posedge clk) disable iff (rst) mem_qr_valid |-> !qid_empty
  ) else $error("Return word with empty queue-ID FIFO");

endmodule

`default_nettype wire

//--- replay_reader.sv
`default_nettype none

module replay_reader import replay_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cal_done,
  output logic                                 mem_r_n,
  output logic [mem_addr_width-1:0]            mem_ad_rd,
  input  logic                                 mem_rd_full,
  input  logic                                 mem_qr_valid,
  input  logic [mem_half_width-1:0]            mem_qrl,
  input  logic [mem_half_width-1:0]            mem_qrh,
  input  logic [num_queues-1:0][head_width-1:0] q_addr_tail,
  output logic [num_queues-1:0][head_width-1:0] q_addr_head,
  input  logic [num_queues-1:0]                q_rd_en,
  output logic [num_queues-1:0][word_width-1:0] q_dout,
  output logic [num_queues-1:0]                q_empty
);

  logic                  qid_wr_en;
  logic [qid_bits-1:0]   qid_din;
  logic                  qid_rd_en;
  logic [qid_bits-1:0]   qid_dout;
  logic                  qid_nearly_full;
  logic                  qid_empty;
  logic [num_queues-1:0] out_wr_en;
  logic [word_width-1:0] out_din;
  logic [num_queues-1:0] out_prog_full;

  queue_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .cal_done        (cal_done),
    .mem_rd_full     (mem_rd_full),
    .mem_r_n         (mem_r_n),
    .mem_ad_rd       (mem_ad_rd),
    .q_addr_tail     (q_addr_tail),
    .q_addr_head     (q_addr_head),
    .out_prog_full   (out_prog_full),
    .qid_nearly_full (qid_nearly_full),
    .qid_wr_en       (qid_wr_en),
    .qid_din         (qid_din)
  );

  // One entry per SRAM read still in flight
  sync_fifo #(
    .width      (qid_bits),
    .depth_bits (qid_fifo_depth_bits)
  ) u_qid_fifo (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (qid_wr_en),
    .rd_en       (qid_rd_en),
    .din         (qid_din),
    .dout        (qid_dout),
    .full        (),
    .nearly_full (qid_nearly_full),
    .prog_full   (),
    .empty       (qid_empty)
  );

  read_return_steer u_steer (
    .clk          (clk),
    .rst          (rst),
    .mem_qr_valid (mem_qr_valid),
    .mem_qrl      (mem_qrl),
    .mem_qrh      (mem_qrh),
    .qid_rd_en    (qid_rd_en),
    .qid_dout     (qid_dout),
    .qid_empty    (qid_empty),
    .out_wr_en    (out_wr_en),
    .out_din      (out_din)
  );

  // Per-queue output buffers toward the consumer
  for (genvar q = 0; q < num_queues; q++) begin : g_out_fifo
    sync_fifo #(
      .width          (word_width),
      .depth_bits     (out_fifo_depth_bits),
      .prog_full_free (out_prog_full_free)
    ) u_out_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en       (out_wr_en[q]),
      .rd_en       (q_rd_en[q]),
      .din         (out_din),
      .dout        (q_dout[q]),
      .full        (),
      .nearly_full (),
      .prog_full   (out_prog_full[q]),
      .empty       (q_empty[q])
    );
  end

endmodule

`default_nettype wire

//--- tb_sram_model.sv
`default_nettype none

module tb_sram_model import replay_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_r_n,
  input  logic [mem_addr_width-1:0] mem_ad_rd,
  input  logic [1:0]                full_rand,
  output logic                      mem_rd_full,
  output logic                      mem_qr_valid,
  output logic [mem_half_width-1:0] mem_qrl,
  output logic [mem_half_width-1:0] mem_qrh
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int latency = 4;

  logic [latency-1:0]        pipe_v = '0;
  logic [mem_addr_width-1:0] pipe_a [latency];
  logic                      full_q = 1'b0;
  logic [mem_addr_width-1:0] ret_addr;
  logic [mem_addr_width-1:0] ret_inv;

  // Read is taken on the edge that sees mem_r_n low
  always @(posedge clk) begin
    if (rst) begin
      pipe_v <= '0;
      full_q <= 1'b0;
    end else begin
      pipe_v <= {pipe_v[latency-2:0], !mem_r_n};
      // Both random bits set, so about one cycle in four
      full_q <= (full_rand == 2'b11);
    end
    pipe_a[0] <= mem_ad_rd;
    for (int i = 1; i < latency; i++) begin
      pipe_a[i] <= pipe_a[i-1];
    end
  end

  assign mem_rd_full = full_q;
  assign mem_qr_valid = pipe_v[latency-1];
  assign ret_addr = pipe_a[latency-1];
  assign ret_inv = ~ret_addr;

  // Low half is the address, high half its inverse
  always_comb begin
    mem_qrl = '0;
    mem_qrh = '0;
    if (mem_qr_valid) begin
      mem_qrl[mem_addr_width-1:0] = ret_addr;
      mem_qrh[mem_addr_width-1:0] = ret_inv;
    end
  end

endmodule

`default_nettype wire

//--- tb_replay_reader.sv
`default_nettype none

module tb_replay_reader import replay_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int stall_queue = 2;
  localparam int stall_cycles = 400;
  localparam int rot_words = 16;
  localparam int more_words = 20;
  localparam int more_words_q2 = 100;
  localparam int total_words = num_queues * rot_words + 3 * more_words + more_words_q2;
  // Reset and calibration, two stall windows, and eight cycles per word
  localparam int timeout_cycles = 14 + 2 * stall_cycles + 8 * total_words;

  logic clk = 1'b0;
  logic rst;
  logic cal_done;
  logic mem_r_n;
  logic [mem_addr_width-1:0] mem_ad_rd;
  logic mem_rd_full;
  logic mem_qr_valid;
  logic [mem_half_width-1:0] mem_qrl;
  logic [mem_half_width-1:0] mem_qrh;
  logic [num_queues-1:0][head_width-1:0] q_addr_tail;
  logic [num_queues-1:0][head_width-1:0] q_addr_head;
  logic [num_queues-1:0] q_rd_en = '0;
  logic [num_queues-1:0][word_width-1:0] q_dout;
  logic [num_queues-1:0] q_empty;

  logic [31:0] lfsr = 32'hb339f91b;
  logic [1:0] full_rand = '0;
  logic quiet_full = 1'b1;
  logic stall_q2 = 1'b0;
  logic consume = 1'b0;
  logic rot_check = 1'b0;
  logic [qid_bits-1:0] rot_next = '0;
  logic [qid_bits-1:0] rd_qid;
  int rot_reads = 0;
  int rd_count [num_queues] = '{default: 0};
  int errs [1:5] = '{default: 0};

  always #5 clk = ~clk;

  replay_reader UUT (
    .clk(clk), .rst(rst), .cal_done(cal_done),
    .mem_r_n(mem_r_n), .mem_ad_rd(mem_ad_rd), .mem_rd_full(mem_rd_full),
    .mem_qr_valid(mem_qr_valid), .mem_qrl(mem_qrl), .mem_qrh(mem_qrh),
    .q_addr_tail(q_addr_tail), .q_addr_head(q_addr_head),
    .q_rd_en(q_rd_en), .q_dout(q_dout), .q_empty(q_empty)
  );

  tb_sram_model u_sram (
    .clk(clk), .rst(rst), .mem_r_n(mem_r_n), .mem_ad_rd(mem_ad_rd),
    .full_rand(full_rand), .mem_rd_full(mem_rd_full), .mem_qr_valid(mem_qr_valid),
    .mem_qrl(mem_qrl), .mem_qrh(mem_qrh)
  );

  assign rd_qid = mem_ad_rd[mem_addr_width-1 -: qid_bits];

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Words are address-derived, high half the inverse of the low half
  function automatic logic [word_width-1:0] expected_word(input int q, input int n);
    logic [mem_addr_width-1:0] addr;
    logic [mem_addr_width-1:0] inv;
    logic [mem_half_width-1:0] lo;
    logic [mem_half_width-1:0] hi;
    addr = {q[qid_bits-1:0], n[head_width-1:0]};
    inv = ~addr;
    lo = '0;
    hi = '0;
    lo[mem_addr_width-1:0] = addr;
    hi[mem_addr_width-1:0] = inv;
    return {hi, lo};
  endfunction

  function automatic logic all_drained();
    logic done;
    done = 1'b1;
    for (int q = 0; q < num_queues; q++) begin
      if (rd_count[q] != int'(q_addr_tail[q])) done = 1'b0;
    end
    return done;
  endfunction

  task automatic report_test(input int k, input string name);
    $display("Test %0d %s: %s, %0d errors", k, name, (errs[k] == 0) ? "ok" : "failed", errs[k]);
  endtask

  // Random read-full and consumer reads; a queue reads at most every other cycle
  always @(posedge clk) begin
    logic [31:0] s;
    logic [5:0] bits;
    s = lfsr;
    for (int i = 0; i < 6; i++) begin
      s = lfsr_step(s);
      bits[i] = s[0];
    end
    lfsr <= s;
    full_rand <= quiet_full ? 2'b00 : bits[1:0];
    for (int q = 0; q < num_queues; q++) begin
      q_rd_en[q] <= consume && !q_empty[q] && !q_rd_en[q] && bits[2 + q]
                    && !(q == stall_queue && stall_q2);
    end
  end

  // Scoreboard, one running word index per queue
  always @(posedge clk) begin
    logic [word_width-1:0] exp_word;
    for (int q = 0; q < num_queues; q++) begin
      if (!rst && q_rd_en[q] && !q_empty[q]) begin
        exp_word = expected_word(q, rd_count[q]);
        assert (q_dout[q] == exp_word) else begin
          $display("CHECK FAILED t=%0t q_dout[%0d] expected %h actual %h",
                   $time, q, exp_word, q_dout[q]);
          errs[2]++;
        end
        assert (rd_count[q] < int'(q_addr_tail[q])) else begin
          $display("Queue %0d delivered a word past its tail at t=%0t", q, $time);
          errs[2]++;
        end
        rd_count[q]++;
      end
    end
  end

  always @(posedge clk) begin
    if (rot_check && !mem_r_n) begin
      assert (rd_qid == rot_next) else begin
        $display("CHECK FAILED t=%0t mem_ad_rd queue expected %0d actual %0d",
                 $time, rot_next, rd_qid);
        errs[4]++;
      end
      rot_next = rd_qid + qid_bits'(1);
      rot_reads++;
    end
  end

  a_cal_no_read: assert property (@(posedge clk) disable iff (rst) !cal_done |-> mem_r_n)
  else begin
    $display("CHECK FAILED t=%0t mem_r_n expected 1 actual %b", $time, $sampled(mem_r_n));
    errs[1]++;
  end

  a_cal_heads_zero: assert property (
    @(posedge clk) disable iff (rst) !cal_done |-> q_addr_head == '0
  ) else begin
    $display("CHECK FAILED t=%0t q_addr_head expected 0 actual %h", $time,
             $sampled(q_addr_head));
    errs[1]++;
  end

  a_no_read_when_full: assert property (
    @(posedge clk) disable iff (rst) !mem_r_n |-> !mem_rd_full
  ) else begin
    $display("CHECK FAILED t=%0t mem_r_n expected 1 actual 0", $time);
    errs[3]++;
  end

  a_read_below_tail: assert property (
    @(posedge clk) disable iff (rst) !mem_r_n |-> q_addr_head[rd_qid] < q_addr_tail[rd_qid]
  ) else begin
    $display("Read at t=%0t names queue %0d whose head is not below its tail", $time,
             $sampled(rd_qid));
    errs[3]++;
  end

  a_stall_no_overflow: assert property (
    @(posedge clk) disable iff (rst) UUT.out_wr_en[2] |-> !UUT.g_out_fifo[2].u_out_fifo.full
  ) else begin
    $display("Queue 2 output FIFO written while full at t=%0t", $time);
    errs[5]++;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the queues never drained", timeout_cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int base [num_queues];
    int total;
    int failed;
    rst = 1'b1;
    cal_done = 1'b0;
    q_addr_tail = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    consume <= 1'b1;
    // Tails raised while calibration still holds the arbiter idle
    rot_check <= 1'b1;
    for (int q = 0; q < num_queues; q++) begin
      q_addr_tail[q] <= head_width'(rot_words);
    end
    repeat (10) @(posedge clk);
    cal_done <= 1'b1;
    repeat (2) @(posedge clk);
    report_test(1, "calibration hold");

    // All queues enabled together with read-full quiet
    while (rot_reads < num_queues * rot_words) @(negedge clk);
    @(posedge clk);
    rot_check <= 1'b0;
    report_test(4, "round-robin rotation");

    quiet_full <= 1'b0;
    stall_q2 <= 1'b1;
    for (int q = 0; q < num_queues; q++) begin
      q_addr_tail[q] <= head_width'(rot_words + ((q == stall_queue) ? more_words_q2 : more_words));
    end
    @(negedge clk);
    for (int q = 0; q < num_queues; q++) base[q] = rd_count[q];
    repeat (stall_cycles) @(negedge clk);
    for (int q = 0; q < num_queues; q++) begin
      if (q != stall_queue) begin
        assert (rd_count[q] > base[q]) else begin
          $display("Queue %0d was not served while queue 2 stalled", q);
          errs[5]++;
        end
      end
    end
    assert (q_addr_head[stall_queue] != q_addr_tail[stall_queue]) else begin
      $display("Queue 2 head reached its tail during the stall without prog-full");
      errs[5]++;
    end
    @(posedge clk);
    stall_q2 <= 1'b0;

    while (!all_drained()) @(negedge clk);
    repeat (4) @(negedge clk);
    for (int q = 0; q < num_queues; q++) begin
      assert (q_addr_head[q] == q_addr_tail[q]) else begin
        $display("CHECK FAILED t=%0t q_addr_head[%0d] expected %h actual %h",
                 $time, q, q_addr_tail[q], q_addr_head[q]);
        errs[2]++;
      end
      assert (q_empty[q]) else begin
        $display("CHECK FAILED t=%0t q_empty[%0d] expected 1 actual 0", $time, q);
        errs[2]++;
      end
    end
    report_test(2, "per-queue data order");
    report_test(3, "read issue rules");
    report_test(5, "queue 2 stall");

    total = 0;
    failed = 0;
    for (int k = 1; k <= 5; k++) begin
      total += errs[k];
      if (errs[k] != 0) failed++;
    end
    $display("Summary: 5 tests, %0d failed, %0d errors", failed, total);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
replay_pkg.sv
sync_fifo.sv
queue_arbiter.sv
read_return_steer.sv
replay_reader.sv
tb_sram_model.sv
tb_replay_reader.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_replay_reader -Mdir obj_dir -o sim_replay_reader

./obj_dir/sim_replay_reader | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
